/* dv/csa_cases.txt */
# ops: T name | I | W addr data strobe | R addr expected | J operands expected | D
# numbers are hex; operands run from byte 4 down to byte 0, a result is 8 times the byte sum.
T reset
I
R 000 00000000
R 001 00000000
R 002 00000000
R 003 00000000
R 004 00000000
R 005 00000000
R 006 00000000
R 007 00000000
R 008 00000000
R 009 00000000
R 00a 00000000
# the pointer starts at zero, so the third job runs on unit 2.
T observe
W 000 00000002 f
J 0102030405 000000000078
J 1122334455 0000000007f8
J a1b2c3d4e5 000000001e78
J ffffffffff 0000000027d8
J 0000000000 000000000000
D
R 001 00000001
R 002 00000001
R 003 000000e5
R 004 000000d4
R 005 000000c3
R 006 000000b2
R 007 000000a1
R 008 00001e78
R 009 00000000
R 00a 00000000
T order
J 0a0b0c0d0e 0000000001e0
J 8040201008 0000000007c0
J ff00ff00ff 0000000017e8
J 0000000001 000000000008
J 7f7f7f7f7f 0000000013d8
J 123456789a 000000000d70
J deadbeef01 0000000019c8
J 0102040810 0000000000f8
J c0ffee0042 000000001778
J 5555555555 000000000d48
J 00000000ff 0000000007f8
J 3c3c3c3c3c 000000000960
D
T channel
W 000 00000007 f
R 000 00000002
W 000 00000003 f
R 000 00000003
W 000 ffffff04 1
R 000 00000004
# seventeen jobs so far leave both pointers at unit 2.
T flags
W 000 00000002 f
R 001 00000000
R 002 00000000
J 0102030405 000000000078
D
R 001 00000001
R 002 00000001
W 000 00000002 f
R 001 00000000
R 002 00000000
T unmapped
R 014 e0000014
R 7ff e00007ff

/* flist.f */
src/csa_pkg.sv
src/csa_if.sv
src/csa_reg_decode.sv
src/csa_dispatch.sv
src/csa_calc_unit.sv
src/csa_result_collect.sv
src/csa_top.sv
dv/tb_csa_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_csa_top -o sim_csa

# the log decides the outcome, so a nonzero exit of the simulation is not fatal here.
./obj_dir/sim_csa > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	exit 1
fi
if ! grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

/* dv/tb_csa_top.sv */
`timescale 1ns/1ps

module tb_csa_top;
	import csa_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst_n;
	logic wen;
	reg_addr_t waddr;
	reg_data_t wdata;
	reg_strb_t wstrb;
	logic ren;
	reg_addr_t raddr;
	reg_data_t rdata;
	logic in_valid;
	logic in_ready;
	operand_bytes_t in_data;
	logic out_valid;
	logic out_ready;
	calc_result_t out_data;

	calc_result_t expected [$];  // results in input order.
	logic [15:0] lfsr;
	string test_name;
	int checks;
	int errors;
	int n_tests;
	int n_failed;
	int test_checks_start;
	int test_errors_start;

	csa_top u_dut (
		.clk, .rst_n, .wen, .waddr, .wdata, .wstrb, .ren, .raddr, .rdata,
		.in_valid, .in_ready, .in_data, .out_valid, .out_ready, .out_data
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// 16-bit Fibonacci register with taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at t=%0t", why, $time);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic close_test();
		int e;
		e = errors - test_errors_start;
		if (test_name != "") begin
			n_tests++;
			if (e != 0) n_failed++;
			$display("test %s: %0d checks, %0d errors, %s", test_name,
				checks - test_checks_start, e, (e == 0) ? "ok" : "bad");
		end
		test_checks_start = checks;
		test_errors_start = errors;
	endtask

	task automatic reg_write(input reg_addr_t addr, input reg_data_t data, input reg_strb_t strb);
		wen = 1'b1;
		waddr = addr;
		wdata = data;
		wstrb = strb;
		@(negedge clk);
		wen = 1'b0;
		repeat (3) @(negedge clk);  // the channel lands on the second edge, the flags one later.
	endtask

	task automatic reg_read(input reg_addr_t addr, input reg_data_t exp);
		ren = 1'b1;
		raddr = addr;
		@(negedge clk);
		ren = 1'b0;
		check_value($sformatf("rdata[%0h]", addr), 64'(exp), 64'(rdata));
	endtask

	task automatic send_job(input operand_bytes_t ops, input calc_result_t exp);
		int waited;
		waited = 0;
		in_data = ops;
		in_valid = 1'b1;
		while (!in_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("timeout: the DUT never accepted a job");
		end
		expected.push_back(exp);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expected.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) abort_run("timeout: results still missing at a drain");
		end
		repeat (3) @(negedge clk);  // lets the capture pulse reach the flags.
	endtask

	task automatic run_line(input string line);
		reg_addr_t addr;
		reg_data_t data;
		reg_strb_t strb;
		operand_bytes_t ops;
		calc_result_t res;
		int n;
		case (line.getc(0))
			"T": begin
				close_test();
				test_name = line.substr(2, line.len() - 2);
			end
			"I": begin
				check_value("out_valid", 64'(0), 64'(out_valid));
				check_value("in_ready", 64'(1), 64'(in_ready));
			end
			"W": begin
				n = $sscanf(line, "W %h %h %h", addr, data, strb);
				if (n != 3) abort_run("a write line in the case file is malformed");
				reg_write(addr, data, strb);
			end
			"R": begin
				n = $sscanf(line, "R %h %h", addr, data);
				if (n != 2) abort_run("a read line in the case file is malformed");
				reg_read(addr, data);
			end
			"J": begin
				n = $sscanf(line, "J %h %h", ops, res);
				if (n != 2) abort_run("a job line in the case file is malformed");
				send_job(ops, res);
			end
			"D": drain();
			"#", "\n", "\r": ;
			default: abort_run("the case file holds an unknown operation");
		endcase
	endtask

	// out_ready is drawn fresh each cycle, and a transfer is checked before its edge.
	initial begin
		out_ready = 1'b0;
		lfsr = 16'd62171;
		forever begin
			@(negedge clk);
			lfsr = lfsr_next(lfsr);
			out_ready = lfsr[0];
			if (out_valid && out_ready) begin
				if (expected.size() == 0) begin
					errors++;
					$display("an output left the DUT with no job outstanding at t=%0t", $time);
				end else begin
					check_value("out_data", 64'(expected.pop_front()), 64'(out_data));
				end
			end
		end
	end

	initial begin
		int fd;
		int n;
		string line;
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		wstrb = '0;
		ren = 1'b0;
		raddr = '0;
		in_valid = 1'b0;
		in_data = '0;
		test_name = "";
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		fd = $fopen("dv/csa_cases.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open dv/csa_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) run_line(line);
			end
			$fclose(fd);
			close_test();
			$display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed,
				checks, errors);
			if (errors == 0 && n_failed == 0 && checks > 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

/* src/csa_top.sv */
`timescale 1ns/1ps

module csa_top (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input csa_pkg::reg_addr_t waddr,
	input csa_pkg::reg_data_t wdata,
	input csa_pkg::reg_strb_t wstrb,
	input logic ren,
	input csa_pkg::reg_addr_t raddr,
	output csa_pkg::reg_data_t rdata,
	input logic in_valid,
	output logic in_ready,
	input csa_pkg::operand_bytes_t in_data,
	output logic out_valid,
	input logic out_ready,
	output csa_pkg::calc_result_t out_data
);
	import csa_pkg::*;

	unit_idx_t channel;
	operand_bytes_t in_snap;
	logic in_capture;
	calc_result_t out_snap;
	logic out_capture;

	csa_job_if job_bus [NUM_UNITS] ();
	csa_result_if res_bus [NUM_UNITS] ();

	csa_reg_decode u_decode (
		.clk, .rst_n, .wen, .waddr, .wdata, .wstrb, .ren, .raddr,
		.in_snap, .in_capture, .out_snap, .out_capture,
		.rdata, .channel, .channel_load()
	);

	csa_dispatch u_dispatch (
		.clk, .rst_n, .in_valid, .in_data, .channel,
		.in_ready, .in_snap, .in_capture, .job(job_bus)
	);

	for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
		csa_calc_unit u_unit (.clk, .rst_n, .job(job_bus[i]), .res(res_bus[i]));
	end

	csa_result_collect u_collect (
		.clk, .rst_n, .out_ready, .channel,
		.out_valid, .out_data, .out_snap, .out_capture, .res(res_bus)
	);

endmodule

/* src/csa_result_collect.sv */
`timescale 1ns/1ps

module csa_result_collect (
	input logic clk,
	input logic rst_n,
	input logic out_ready,
	input csa_pkg::unit_idx_t channel,
	output logic out_valid,
	output csa_pkg::calc_result_t out_data,
	output csa_pkg::calc_result_t out_snap,
	output logic out_capture,
	csa_result_if.collect res [csa_pkg::NUM_UNITS]
);
	import csa_pkg::*;

	unit_idx_t ptr;
	logic [NUM_UNITS-1:0] unit_valid;
	calc_result_t unit_result [NUM_UNITS];
	logic xfer;

	for (genvar i = 0; i < NUM_UNITS; i++) begin : g_res
		assign unit_valid[i] = res[i].valid;
		assign unit_result[i] = res[i].result;
		assign res[i].ready = out_ready && (ptr == unit_idx_t'(i));
	end

	// the pointer follows the dispatch rotation, so results leave in input order.
	assign out_valid = unit_valid[ptr];
	assign out_data = unit_result[ptr];
	assign xfer = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (xfer) begin
			if (ptr == unit_idx_t'(NUM_UNITS - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_capture <= 1'b0;
		end else begin
			out_capture <= xfer && (ptr == channel);
		end
	end

	always_ff @(posedge clk) begin
		if (xfer && ptr == channel) out_snap <= out_data;
	end

	// the output must hold across a stall, which relies on the unit keeping its result.
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* src/csa_calc_unit.sv */
`timescale 1ns/1ps

module csa_calc_unit (
	input logic clk,
	input logic rst_n,
	csa_job_if.unit job,
	csa_result_if.unit res
);
	import csa_pkg::*;

	calc_state_t state;
	logic [ROUND_BITS-1:0] round;
	operand_bytes_t ops_q;
	calc_result_t sum_q;
	calc_result_t carry_q;
	calc_result_t sum_nxt;
	calc_result_t carry_nxt;
	calc_result_t result_q;

	// one round folds all five bytes into the redundant pair with 3:2 compressors.
	function automatic void csa_round(input calc_result_t s_in, input calc_result_t c_in,
		input operand_bytes_t ops, output calc_result_t s_out, output calc_result_t c_out);
		calc_result_t s;
		calc_result_t c;
		calc_result_t b;
		calc_result_t t;
		s = s_in;
		c = c_in;
		for (int k = 0; k < OPERAND_BYTES; k++) begin
			b = calc_result_t'(ops[8*k +: 8]);
			t = s ^ c ^ b;
			c = ((s & c) | (s & b) | (c & b)) << 1;
			s = t;
		end
		s_out = s;
		c_out = c;
	endfunction

	always_comb csa_round(sum_q, carry_q, ops_q, sum_nxt, carry_nxt);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= calc_idle;
			round <= '0;
		end else begin
			case (state)
				calc_idle: if (job.valid) state <= calc_accumulate;
				calc_accumulate: begin
					round <= round + 1'b1;
					if (round == ROUND_BITS'(CALC_ROUNDS - 1)) state <= calc_resolve;
				end
				calc_resolve: state <= calc_done;
				calc_done: if (res.ready) state <= calc_idle;
				default: state <= calc_idle;
			endcase
			if (state == calc_idle) round <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == calc_idle && job.valid) begin
			ops_q <= job.operands;
			sum_q <= '0;
			carry_q <= '0;
		end else if (state == calc_accumulate) begin
			sum_q <= sum_nxt;
			carry_q <= carry_nxt;
		end
		if (state == calc_resolve) result_q <= sum_q + carry_q;  // the single carry-propagate add.
	end

	assign job.ready = (state == calc_idle);
	assign res.valid = (state == calc_done);
	assign res.result = result_q;

	// an accepted job leaves idle at once and drops ready.
	a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
		job.valid && job.ready |=> state == calc_accumulate && !job.ready);

	a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res.valid && !res.ready |=> res.valid && $stable(res.result));

endmodule

/* src/csa_dispatch.sv */
`timescale 1ns/1ps

module csa_dispatch (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input csa_pkg::operand_bytes_t in_data,
	input csa_pkg::unit_idx_t channel,
	output logic in_ready,
	output csa_pkg::operand_bytes_t in_snap,
	output logic in_capture,
	csa_job_if.dispatch job [csa_pkg::NUM_UNITS]
);
	import csa_pkg::*;

	unit_idx_t ptr;
	logic [NUM_UNITS-1:0] unit_ready;
	logic accept;

	// interface arrays need constant indices, so each entry gets its own wiring.
	for (genvar i = 0; i < NUM_UNITS; i++) begin : g_job
		assign job[i].valid = in_valid && (ptr == unit_idx_t'(i));
		assign job[i].operands = in_data;  // only the named unit sees valid.
		assign unit_ready[i] = job[i].ready;
	end

	assign in_ready = unit_ready[ptr];
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (accept) begin
			if (ptr == unit_idx_t'(NUM_UNITS - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_capture <= 1'b0;
		end else begin
			in_capture <= accept && (ptr == channel);
		end
	end

	always_ff @(posedge clk) begin
		if (accept && ptr == channel) begin
			in_snap <= in_data;  // operands of the last job on the observed unit.
		end
	end

endmodule

/* src/csa_reg_decode.sv */
`timescale 1ns/1ps

module csa_reg_decode (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input csa_pkg::reg_addr_t waddr,
	input csa_pkg::reg_data_t wdata,
	input csa_pkg::reg_strb_t wstrb,
	input logic ren,
	input csa_pkg::reg_addr_t raddr,
	input csa_pkg::operand_bytes_t in_snap,
	input logic in_capture,
	input csa_pkg::calc_result_t out_snap,
	input logic out_capture,
	output csa_pkg::reg_data_t rdata,
	output csa_pkg::unit_idx_t channel,
	output logic channel_load
);
	import csa_pkg::*;

	reg_addr_t wr_addr_q;
	reg_data_t wr_data_q;
	logic wr_pend_q;
	operand_bytes_t in_bytes_q;
	calc_result_t out_result_q;
	logic in_flag;
	logic out_flag;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_addr_q <= '0;
			wr_data_q <= '0;
			wr_pend_q <= 1'b0;
		end else begin
			wr_pend_q <= wen;
			if (wen) begin
				wr_addr_q <= waddr;
				for (int b = 0; b < $bits(reg_strb_t); b++) begin
					if (wstrb[b]) wr_data_q[8*b +: 8] <= wdata[8*b +: 8];  // unstrobed lanes keep the last write.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			channel <= '0;
			channel_load <= 1'b0;
		end else begin
			channel_load <= 1'b0;
			if (wr_pend_q && wr_addr_q == ADDR_CHANNEL && wr_data_q < NUM_UNITS) begin
				channel <= unit_idx_t'(wr_data_q);
				channel_load <= 1'b1;
			end
		end
	end

	// a capture seen with channel_load belongs to the old channel, so the clear wins.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_bytes_q <= '0;
			out_result_q <= '0;
			in_flag <= 1'b0;
			out_flag <= 1'b0;
		end else begin
			if (in_capture) in_bytes_q <= in_snap;
			if (out_capture) out_result_q <= out_snap;
			if (channel_load) begin
				in_flag <= 1'b0;
				out_flag <= 1'b0;
			end else begin
				if (in_capture) in_flag <= 1'b1;
				if (out_capture) out_flag <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			case (raddr)
				ADDR_CHANNEL: rdata <= {{(REG_DATA_BITS - $bits(unit_idx_t)){1'b0}}, channel};
				ADDR_IN_FLAG: rdata <= {{(REG_DATA_BITS - 1){1'b0}}, in_flag};
				ADDR_OUT_FLAG: rdata <= {{(REG_DATA_BITS - 1){1'b0}}, out_flag};
				ADDR_IN_BYTE0: rdata <= {24'b0, in_bytes_q[7:0]};
				ADDR_IN_BYTE1: rdata <= {24'b0, in_bytes_q[15:8]};
				ADDR_IN_BYTE2: rdata <= {24'b0, in_bytes_q[23:16]};
				ADDR_IN_BYTE3: rdata <= {24'b0, in_bytes_q[31:24]};
				ADDR_IN_BYTE4: rdata <= {24'b0, in_bytes_q[39:32]};
				ADDR_OUT_HALF0: rdata <= {16'b0, out_result_q[15:0]};
				ADDR_OUT_HALF1: rdata <= {16'b0, out_result_q[31:16]};
				ADDR_OUT_HALF2: rdata <= {16'b0, out_result_q[47:32]};
				default: rdata <= {UNMAPPED_TAG, {(16 - REG_ADDR_BITS){1'b0}}, raddr};
			endcase
		end
	end

endmodule

/* src/csa_if.sv */
`timescale 1ns/1ps

// one job travels from the dispatcher to a single unit.
interface csa_job_if;
	import csa_pkg::*;

	logic valid;
	logic ready;
	operand_bytes_t operands;

	modport dispatch (output valid, output operands, input ready);
	modport unit (input valid, input operands, output ready);

endinterface

interface csa_result_if;
	import csa_pkg::*;

	logic valid;  // held with result until ready.
	logic ready;
	calc_result_t result;

	modport unit (output valid, output result, input ready);
	modport collect (input valid, input result, output ready);

endinterface

/* src/csa_pkg.sv */
package csa_pkg;

	localparam int NUM_UNITS = 5;
	localparam int CALC_ROUNDS = 8;
	localparam int ROUND_BITS = $clog2(CALC_ROUNDS);  // counts rounds 0 to CALC_ROUNDS-1.
	localparam int OPERAND_BYTES = 5;
	localparam int RESULT_BITS = 48;
	localparam int REG_ADDR_BITS = 11;
	localparam int REG_DATA_BITS = 32;

	typedef logic [8*OPERAND_BYTES-1:0] operand_bytes_t;  // byte 0 sits lowest.
	typedef logic [RESULT_BITS-1:0] calc_result_t;
	typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
	typedef logic [REG_DATA_BITS-1:0] reg_data_t;
	typedef logic [REG_DATA_BITS/8-1:0] reg_strb_t;
	typedef logic [2:0] unit_idx_t;

	typedef enum logic [1:0] {
		calc_idle,
		calc_accumulate,
		calc_resolve,
		calc_done
	} calc_state_t;

	localparam reg_addr_t ADDR_CHANNEL = 11'd0;
	localparam reg_addr_t ADDR_IN_FLAG = 11'd1;
	localparam reg_addr_t ADDR_OUT_FLAG = 11'd2;
	localparam reg_addr_t ADDR_IN_BYTE0 = 11'd3;
	localparam reg_addr_t ADDR_IN_BYTE1 = 11'd4;
	localparam reg_addr_t ADDR_IN_BYTE2 = 11'd5;
	localparam reg_addr_t ADDR_IN_BYTE3 = 11'd6;
	localparam reg_addr_t ADDR_IN_BYTE4 = 11'd7;
	localparam reg_addr_t ADDR_OUT_HALF0 = 11'd8;
	localparam reg_addr_t ADDR_OUT_HALF1 = 11'd9;
	localparam reg_addr_t ADDR_OUT_HALF2 = 11'd10;

	localparam logic [15:0] UNMAPPED_TAG = 16'hE000;  // upper half of an unmapped read.

endpackage
